/* hw/imuldiv_msg_pkg.sv */
// request and response message types for the multiply/divide unit
// function codes, operand width and the two views of the result word

package imuldiv_msg_pkg;

  // ---------------------------------------------------------------------------
  // operand width and function codes
  // ---------------------------------------------------------------------------

  // default operand width; the top level passes its own width down
  localparam int XLEN = 32;

  // MUL is always signed
  // DIV and DIVU both return remainder and quotient
  typedef enum logic [1:0] {
    FN_MUL  = 2'd0,
    FN_DIV  = 2'd1,
    FN_DIVU = 2'd2
  } fn_e;

  // ---------------------------------------------------------------------------
  // response word
  // ---------------------------------------------------------------------------

  // divide view, remainder in the upper half
  typedef struct packed {
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quot;
  } div_result_t;

  // the same 64-bit word is read as a full product after MUL
  // or as a rem/quot pair after DIV and DIVU
  typedef union packed {
    logic [2*XLEN-1:0] product;
    div_result_t       div;
  } result_u;

endpackage

/* hw/imuldiv_ctrl_pkg.sv */
// types shared by the iteration controller and its observers
// FSM state encoding and step counter width

package imuldiv_ctrl_pkg;

  // idle until a request is accepted, calc for one step per bit,
  // then done until the response is taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_e;

  // wide enough to count the steps of a 32-bit operation
  localparam int count_w = 6;

endpackage

/* hw/imuldiv_unit_if.sv */
// channel between the dispatcher and one arithmetic unit
// carries the request, the step controls and the response

`timescale 1ns/1ps

interface imuldiv_unit_if #(
  parameter int width = imuldiv_msg_pkg::XLEN
) ();

  import imuldiv_msg_pkg::*;

  // request side
  logic             req_val;
  logic             req_rdy;
  fn_e              req_fn;
  logic [width-1:0] req_a;
  logic [width-1:0] req_b;

  // controller to datapath
  // load pulses on the accept edge, step is high through calc
  logic             load;
  logic             step;

  // response side
  logic             resp_val;
  logic             resp_rdy;
  result_u          resp_result;

  modport host  (output req_val, req_fn, req_a, req_b, resp_rdy,
                 input  req_rdy, resp_val, resp_result);

  modport ctrl  (input  req_val, resp_rdy,
                 output req_rdy, resp_val, load, step);

  modport dpath (input  req_fn, req_a, req_b, load, step,
                 output resp_result);

endinterface

/* hw/imuldiv_iter_ctrl.sv */
// iteration FSM and step counter
// one instance sits beside each datapath and owns its val/rdy handshake

`timescale 1ns/1ps

module imuldiv_iter_ctrl #(
  parameter int width = imuldiv_msg_pkg::XLEN
) (
  input logic          clk,
  input logic          reset,
  imuldiv_unit_if.ctrl port
);

  import imuldiv_ctrl_pkg::*;

  iter_state_e        state;
  logic [count_w-1:0] count;

  logic accept;
  logic send;
  logic last_step;

  // handshakes as seen by this unit
  assign accept    = port.req_val && port.req_rdy;
  assign send      = port.resp_val && port.resp_rdy;
  assign last_step = (count == count_w'(width - 1));

  // ---------------------------------------------------------------------------
  // state and counter
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      count <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            state <= CALC;
            count <= '0;
          end
        end
        CALC: begin
          // exactly width steps, the last one moves to done
          if (last_step) begin
            state <= DONE;
          end else begin
            count <= count + 1'b1;
          end
        end
        DONE: begin
          // hold the response until the host takes it
          if (send) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // outputs, pure decode of the state
  // ---------------------------------------------------------------------------

  assign port.req_rdy  = (state == IDLE);
  assign port.resp_val = (state == DONE);
  assign port.load     = accept;
  assign port.step     = (state == CALC);

  // a unit never offers a response while it would take a new request
  a_rdy_val_excl: assert property (@(posedge clk) disable iff (reset)
    !(port.resp_val && port.req_rdy));

  a_step_in_calc: assert property (@(posedge clk) disable iff (reset)
    port.step |-> (state == CALC));

  // every load is followed by width steps and then a valid response
  a_step_count: assert property (@(posedge clk) disable iff (reset)
    port.load |=> port.step [*width] ##1 (port.resp_val && !port.step));

endmodule

/* hw/imuldiv_div_dpath.sv */
// restoring divider datapath for DIV and DIVU
// sign stripping, one quotient bit per step, sign fix-up on the result

`timescale 1ns/1ps

module imuldiv_div_dpath #(
  parameter int width = imuldiv_msg_pkg::XLEN
) (
  input logic           clk,
  input logic           reset,
  imuldiv_unit_if.dpath port
);

  import imuldiv_msg_pkg::*;

  logic             is_div;
  logic [width-1:0] mag_a;
  logic [width-1:0] mag_b;

  // remainder in the upper half, quotient shifts in at the bottom
  logic [2*width:0] rq_reg;
  // divisor magnitude parked in the upper half
  logic [2*width:0] dvs_reg;

  logic             neg_quot;
  logic             neg_rem;

  logic [2*width:0] shifted;
  logic [2*width:0] diff;
  logic [width-1:0] quot_mag;
  logic [width-1:0] rem_mag;
  logic [width-1:0] quot_fix;
  logic [width-1:0] rem_fix;
  result_u          result;

  // ---------------------------------------------------------------------------
  // operand magnitudes
  // ---------------------------------------------------------------------------

  // DIVU takes the operands as they are
  assign is_div = (port.req_fn == FN_DIV);
  assign mag_a  = (is_div && port.req_a[width-1]) ? -port.req_a : port.req_a;
  assign mag_b  = (is_div && port.req_b[width-1]) ? -port.req_b : port.req_b;

  // ---------------------------------------------------------------------------
  // restoring loop
  // ---------------------------------------------------------------------------

  assign shifted = rq_reg << 1;
  assign diff    = shifted - dvs_reg;

  always_ff @(posedge clk) begin
    if (port.load) begin
      rq_reg  <= {{(width + 1){1'b0}}, mag_a};
      dvs_reg <= {1'b0, mag_b, {width{1'b0}}};
    end else if (port.step) begin
      // negative difference means the divisor did not fit, restore
      if (diff[2*width]) begin
        rq_reg <= {shifted[2*width:1], 1'b0};
      end else begin
        rq_reg <= {diff[2*width:1], 1'b1};
      end
    end
  end

  // result signs, only DIV can produce a negative result
  always_ff @(posedge clk) begin
    if (reset) begin
      neg_quot <= 1'b0;
      neg_rem  <= 1'b0;
    end else if (port.load) begin
      neg_quot <= is_div && (port.req_a[width-1] ^ port.req_b[width-1]);
      neg_rem  <= is_div && port.req_a[width-1];
    end
  end

  // ---------------------------------------------------------------------------
  // sign fix-up
  // ---------------------------------------------------------------------------

  // zero divisor falls out as all-ones quotient, dividend as remainder
  assign quot_mag = rq_reg[width-1:0];
  assign rem_mag  = rq_reg[2*width-1:width];
  assign quot_fix = neg_quot ? -quot_mag : quot_mag;
  // remainder follows the dividend sign
  assign rem_fix  = neg_rem ? -rem_mag : rem_mag;

  always_comb begin
    result.div.rem  = rem_fix;
    result.div.quot = quot_fix;
  end

  assign port.resp_result = result;

  // the dispatcher must never hand a multiply to this unit
  a_load_is_div: assert property (@(posedge clk) disable iff (reset)
    port.load |-> (port.req_fn != FN_MUL));

endmodule

/* hw/imuldiv_mul_dpath.sv */
// shift-add multiplier datapath for signed MUL
// magnitudes in, one multiplier bit per step, product sign fix-up out

`timescale 1ns/1ps

module imuldiv_mul_dpath #(
  parameter int width = imuldiv_msg_pkg::XLEN
) (
  input logic           clk,
  input logic           reset,
  imuldiv_unit_if.dpath port
);

  import imuldiv_msg_pkg::*;

  logic [width-1:0]   mag_a;
  logic [width-1:0]   mag_b;

  // multiplicand magnitude, fixed for the whole operation
  logic [width-1:0]   mcand_reg;
  // partial product on top, unconsumed multiplier bits below
  logic [2*width-1:0] acc_reg;
  logic               neg_prod;

  logic [width:0]     upper_sum;
  logic [width:0]     upper_next;

  // ---------------------------------------------------------------------------
  // operand magnitudes, MUL is always signed
  // ---------------------------------------------------------------------------

  assign mag_a = port.req_a[width-1] ? -port.req_a : port.req_a;
  assign mag_b = port.req_b[width-1] ? -port.req_b : port.req_b;

  // ---------------------------------------------------------------------------
  // shift-add loop
  // ---------------------------------------------------------------------------

  // carry kept so the right shift brings it into the top bit
  assign upper_sum  = {1'b0, acc_reg[2*width-1:width]} + {1'b0, mcand_reg};
  assign upper_next = acc_reg[0] ? upper_sum : {1'b0, acc_reg[2*width-1:width]};

  always_ff @(posedge clk) begin
    if (port.load) begin
      mcand_reg <= mag_a;
      acc_reg   <= {{width{1'b0}}, mag_b};
    end else if (port.step) begin
      acc_reg <= {upper_next, acc_reg[width-1:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      neg_prod <= 1'b0;
    end else if (port.load) begin
      neg_prod <= port.req_a[width-1] ^ port.req_b[width-1];
    end
  end

  // ---------------------------------------------------------------------------
  // product sign fix-up
  // ---------------------------------------------------------------------------

  assign port.resp_result.product = neg_prod ? -acc_reg : acc_reg;

  // divides are routed elsewhere
  a_load_is_mul: assert property (@(posedge clk) disable iff (reset)
    port.load |-> (port.req_fn == FN_MUL));

endmodule

/* hw/imuldiv_dispatch.sv */
// request router and response multiplexer
// one operation in flight, owner recorded on accept

`timescale 1ns/1ps

module imuldiv_dispatch #(
  parameter int width = imuldiv_msg_pkg::XLEN
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    req_val,
  output logic                    req_rdy,
  input  imuldiv_msg_pkg::fn_e    req_fn,
  input  logic [width-1:0]        req_a,
  input  logic [width-1:0]        req_b,
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output imuldiv_msg_pkg::result_u resp_result,
  imuldiv_unit_if.host            mul_port,
  imuldiv_unit_if.host            div_port
);

  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;

  logic sel_mul;
  logic busy;
  // set when the multiplier owns the operation in flight
  logic owner_mul;

  // unit state as seen from its handshake lines
  function automatic iter_state_e unit_state(input logic rdy, input logic val);
    iter_state_e st;
    if (rdy) begin
      st = IDLE;
    end else if (val) begin
      st = DONE;
    end else begin
      st = CALC;
    end
    return st;
  endfunction

  assign sel_mul = (req_fn == FN_MUL);

  // ---------------------------------------------------------------------------
  // request routing
  // ---------------------------------------------------------------------------

  // operands go to both units, only the chosen one sees val
  assign mul_port.req_val = req_val && !busy && sel_mul;
  assign mul_port.req_fn  = req_fn;
  assign mul_port.req_a   = req_a;
  assign mul_port.req_b   = req_b;

  assign div_port.req_val = req_val && !busy && !sel_mul;
  assign div_port.req_fn  = req_fn;
  assign div_port.req_a   = req_a;
  assign div_port.req_b   = req_b;

  assign req_rdy = !busy && (sel_mul ? mul_port.req_rdy : div_port.req_rdy);

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      owner_mul <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy      <= 1'b1;
      owner_mul <= sel_mul;
    end else if (resp_val && resp_rdy) begin
      busy      <= 1'b0;
    end
  end

  // ---------------------------------------------------------------------------
  // response steering, owner only
  // ---------------------------------------------------------------------------

  assign resp_val          = owner_mul ? mul_port.resp_val : div_port.resp_val;
  assign resp_result       = owner_mul ? mul_port.resp_result : div_port.resp_result;
  assign mul_port.resp_rdy = resp_rdy && owner_mul;
  assign div_port.resp_rdy = resp_rdy && !owner_mul;

  a_one_active: assert property (@(posedge clk) disable iff (reset)
    (unit_state(mul_port.req_rdy, mul_port.resp_val) == IDLE) ||
    (unit_state(div_port.req_rdy, div_port.resp_val) == IDLE));

  // a stalled response holds its value until taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> (resp_val && $stable(resp_result)));

endmodule

/* hw/imuldiv_top.sv */
// multiply/divide unit top level
// dispatcher plus one controller and datapath per function group

`timescale 1ns/1ps

module imuldiv_top #(
  parameter int width = imuldiv_msg_pkg::XLEN
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req_val,
  output logic                     req_rdy,
  input  imuldiv_msg_pkg::fn_e     req_fn,
  input  logic [width-1:0]         req_a,
  input  logic [width-1:0]         req_b,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output imuldiv_msg_pkg::result_u resp_result
);

  // one channel per unit
  imuldiv_unit_if #(.width(width)) mul_if ();
  imuldiv_unit_if #(.width(width)) div_if ();

  imuldiv_dispatch #(.width(width)) dispatch_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result),
    .mul_port    (mul_if.host),
    .div_port    (div_if.host)
  );

  // ---------------------------------------------------------------------------
  // multiplier
  // ---------------------------------------------------------------------------

  imuldiv_iter_ctrl #(.width(width)) mul_ctrl_i (
    .clk   (clk),
    .reset (reset),
    .port  (mul_if.ctrl)
  );

  imuldiv_mul_dpath #(.width(width)) mul_dpath_i (
    .clk   (clk),
    .reset (reset),
    .port  (mul_if.dpath)
  );

  // ---------------------------------------------------------------------------
  // divider
  // ---------------------------------------------------------------------------

  imuldiv_iter_ctrl #(.width(width)) div_ctrl_i (
    .clk   (clk),
    .reset (reset),
    .port  (div_if.ctrl)
  );

  imuldiv_div_dpath #(.width(width)) div_dpath_i (
    .clk   (clk),
    .reset (reset),
    .port  (div_if.dpath)
  );

endmodule

/* verification/imuldiv_tb.sv */
// testbench for the multiply/divide unit
// LFSR stimulus, reference model, response checker and watchdog

`timescale 1ns/1ps

module imuldiv_tb;

  import imuldiv_msg_pkg::*;

  localparam int width      = 32;
  localparam int latency    = 33;
  localparam int max_stall  = 8;
  localparam int reset_cyc  = 2;
  localparam int max_tests  = 64;

  logic             clk;
  logic             reset;
  logic             req_val;
  logic             req_rdy;
  fn_e              req_fn;
  logic [width-1:0] req_a;
  logic [width-1:0] req_b;
  logic             resp_val;
  logic             resp_rdy;
  result_u          resp_result;

  // test table, filled at time zero
  string            name_tab [0:max_tests-1];
  fn_e              fn_tab   [0:max_tests-1];
  logic [width-1:0] a_tab    [0:max_tests-1];
  logic [width-1:0] b_tab    [0:max_tests-1];
  logic [63:0]      exp_tab  [0:max_tests-1];
  int               n_tests = 0;
  logic             tests_ready = 1'b0;

  logic [31:0] lfsr_state = 32'heba52eb4;
  int          cycle = 0;
  int          errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          accept_count = 0;
  int          resp_count = 0;
  int          stall_left = 0;

  // checker state
  logic        in_flight = 1'b0;
  logic        resp_seen = 1'b0;
  logic        held = 1'b0;
  logic        test_bad = 1'b0;
  logic        check_rdy_next = 1'b0;
  logic [63:0] held_result;
  int          accept_cycle;

  imuldiv_top #(.width(width)) dut_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  // ---------------------------------------------------------------------------
  // helpers
  // ---------------------------------------------------------------------------

  // taps 32, 22, 2, 1; one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val        = {val[30:0], fb};
    end
    return val;
  endfunction

  // expected response word: magnitudes, unsigned op, then sign fix-up
  function automatic logic [63:0] imuldiv_ref(input fn_e fn, input logic [31:0] a,
                                              input logic [31:0] b);
    logic        sa;
    logic        sb;
    logic [31:0] ma;
    logic [31:0] mb;
    logic [31:0] q;
    logic [31:0] r;
    logic [63:0] p;
    sa = (fn != FN_DIVU) && a[31];
    sb = (fn != FN_DIVU) && b[31];
    ma = sa ? -a : a;
    mb = sb ? -b : b;
    if (fn == FN_MUL) begin
      p = {32'b0, ma} * {32'b0, mb};
      return (sa ^ sb) ? -p : p;
    end
    // zero divisor gives all ones and the dividend magnitude
    if (mb == 32'd0) begin
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (sa ^ sb) q = -q;
    if (sa) r = -r;
    return {r, q};
  endfunction

  task automatic add_test(input string name, input fn_e fn, input logic [31:0] a,
                          input logic [31:0] b);
    name_tab[n_tests] = name;
    fn_tab[n_tests]   = fn;
    a_tab[n_tests]    = a;
    b_tab[n_tests]    = b;
    n_tests++;
  endtask

  task automatic build_tests();
    add_test("divu_zero_div", FN_DIVU, rand_bits(32), 32'd0);
    add_test("divu_by_one", FN_DIVU, rand_bits(32), 32'd1);
    add_test("divu_small", FN_DIVU, 32'd12345, 32'hf000_0000);
    for (int i = 0; i < 4; i++)
      add_test($sformatf("divu_rand%0d", i), FN_DIVU, rand_bits(32), rand_bits(32));
    for (int i = 0; i < 4; i++)
      add_test($sformatf("div_rand%0d", i), FN_DIV, rand_bits(32), rand_bits(32));
    add_test("div_neg_pos", FN_DIV, -32'sd7, 32'sd2);
    add_test("div_pos_neg", FN_DIV, 32'sd7, -32'sd2);
    add_test("div_neg_neg", FN_DIV, -32'sd7, -32'sd2);
    add_test("div_min_m1", FN_DIV, 32'h8000_0000, 32'hffff_ffff);
    add_test("div_zero_neg", FN_DIV, -32'sd12345, 32'd0);
    add_test("div_zero_pos", FN_DIV, 32'sd12345, 32'd0);
    for (int i = 0; i < 4; i++)
      add_test($sformatf("mul_rand%0d", i), FN_MUL, rand_bits(32), rand_bits(32));
    add_test("mul_zero", FN_MUL, rand_bits(32), 32'd0);
    add_test("mul_min_min", FN_MUL, 32'h8000_0000, 32'h8000_0000);
    add_test("mul_min_m1", FN_MUL, 32'h8000_0000, 32'hffff_ffff);
    add_test("mul_min_one", FN_MUL, 32'h8000_0000, 32'd1);
    // back-to-back pairs switching units every request
    for (int i = 0; i < 6; i++) begin
      add_test($sformatf("alt_mul%0d", i), FN_MUL, rand_bits(32), rand_bits(32));
      add_test($sformatf("alt_div%0d", i), FN_DIV, rand_bits(32), rand_bits(32));
    end
  endtask

  // ---------------------------------------------------------------------------
  // response back-pressure, random stall per response
  // ---------------------------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      stall_left = 0;
      resp_rdy  <= 1'b0;
    end else if (resp_val && resp_rdy) begin
      stall_left = rand_bits(3);
      resp_rdy  <= (stall_left == 0);
    end else if (resp_val && !resp_rdy) begin
      if (stall_left == 0)
        resp_rdy <= 1'b1;
      else
        stall_left--;
    end
  end

  // ---------------------------------------------------------------------------
  // checker, samples at the rising edge before the DUT updates
  // ---------------------------------------------------------------------------

  always @(posedge clk) begin : resp_check
    logic [63:0] actual;
    int          lat;
    if (!reset) begin
      actual = resp_result;
      if (check_rdy_next && !req_rdy) begin
        $display("req_rdy stayed low in the cycle after a response transfer");
        errors++;
      end
      check_rdy_next = 1'b0;
      if (in_flight && req_rdy) begin
        $display("req_rdy high while %s was in flight", name_tab[accept_count - 1]);
        errors++;
        test_bad = 1'b1;
      end
      if (resp_val && !in_flight) begin
        $display("resp_val high with no request in flight");
        errors++;
      end
      if (held && (!resp_val || actual !== held_result)) begin
        $display("response of %s changed while stalled", name_tab[resp_count]);
        errors++;
        test_bad = 1'b1;
      end
      if (resp_val && in_flight && !resp_seen) begin
        resp_seen = 1'b1;
        lat       = cycle - accept_cycle;
        if (lat != latency) begin
          $display("CHECK FAILED %s latency expected %0d actual %0d",
                   name_tab[resp_count], latency, lat);
          errors++;
          test_bad = 1'b1;
        end
      end
      if (req_val && req_rdy) begin
        exp_tab[accept_count] = imuldiv_ref(req_fn, req_a, req_b);
        accept_cycle = cycle;
        in_flight    = 1'b1;
        resp_seen    = 1'b0;
        accept_count++;
      end
      if (resp_val && resp_rdy && in_flight) begin
        if (actual !== exp_tab[resp_count]) begin
          $display("CHECK FAILED %s expected %h actual %h",
                   name_tab[resp_count], exp_tab[resp_count], actual);
          errors++;
          test_bad = 1'b1;
        end else if (test_bad) begin
          $display("test %s finished with errors", name_tab[resp_count]);
        end else begin
          $display("test %s ok, result %h", name_tab[resp_count], actual);
        end
        if (test_bad)
          failed++;
        else
          passed++;
        test_bad       = 1'b0;
        in_flight      = 1'b0;
        check_rdy_next = 1'b1;
        resp_count++;
      end
      held        = resp_val && !resp_rdy;
      held_result = actual;
    end
  end

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------

  initial begin
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = FN_MUL;
    req_a    = '0;
    req_b    = '0;
    resp_rdy = 1'b0;
    build_tests();
    tests_ready = 1'b1;
    repeat (reset_cyc) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    if (!req_rdy || resp_val) begin
      $display("after reset req_rdy is %b and resp_val is %b", req_rdy, resp_val);
      errors++;
    end
    // next request is offered right after each accept
    for (int i = 0; i < n_tests; i++) begin
      req_val <= 1'b1;
      req_fn  <= fn_tab[i];
      req_a   <= a_tab[i];
      req_b   <= b_tab[i];
      @(posedge clk);
      while (!(req_val && req_rdy)) @(posedge clk);
    end
    req_val <= 1'b0;
    wait (resp_count == n_tests);
    @(posedge clk);
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             n_tests, passed, failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog sized from the test count
  initial begin : watchdog
    int limit;
    wait (tests_ready);
    limit = n_tests * (latency + max_stall + 4) + reset_cyc;
    while (cycle < limit) @(posedge clk);
    $display("timeout after %0d cycles with %0d of %0d responses received",
             cycle, resp_count, n_tests);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* imuldiv.f */
hw/imuldiv_msg_pkg.sv
hw/imuldiv_ctrl_pkg.sv
hw/imuldiv_unit_if.sv
hw/imuldiv_iter_ctrl.sv
hw/imuldiv_div_dpath.sv
hw/imuldiv_mul_dpath.sv
hw/imuldiv_dispatch.sv
hw/imuldiv_top.sv
verification/imuldiv_tb.sv
